//--- Bender.yml
package:
  name: cbuf

sources:
  # packages first, then the design bottom up
  - verilog/cbuf_cfg_pkg.sv
  - verilog/cbuf_addr_pkg.sv
  - verilog/cbuf_wr_decode.sv
  - verilog/cbuf_rd_decode.sv
  - verilog/cbuf_bank_array.sv
  - verilog/cbuf_rd_merge.sv
  - verilog/cbuf_top.sv
  # testbench sources
  - target: test
    files:
      - testbench/cbuf_chk.sv
      - testbench/cbuf_tb.sv

//--- project.f
verilog/cbuf_cfg_pkg.sv
verilog/cbuf_addr_pkg.sv
verilog/cbuf_wr_decode.sv
verilog/cbuf_rd_decode.sv
verilog/cbuf_bank_array.sv
verilog/cbuf_rd_merge.sv
verilog/cbuf_top.sv
testbench/cbuf_chk.sv
testbench/cbuf_tb.sv

//--- testbench/cbuf_chk.sv
// convolution buffer port checker
// usage rules of the write and read ports and the fixed read latency,
// bound onto the top level

`timescale 1ns/1ps

module cbuf_chk
  import cbuf_cfg_pkg::*;
  import cbuf_addr_pkg::*;
(
  input logic       nvdla_core_clk,
  input logic       reset,
  input logic       wr0_en,
  input cbuf_addr_u wr0_addr,
  input logic       wr1_en,
  input cbuf_addr_u wr1_addr,
  input logic       dat_rd_en,
  input cbuf_addr_u dat_rd_addr,
  input logic       wt_rd_en,
  input cbuf_addr_u wt_rd_addr,
  input logic       dat_rd_valid,
  input logic       wt_rd_valid
);

  // ============================================================
  // bank conflicts
  // ============================================================

  // feature and weight writes go to different banks
  wr_bank_conflict : assert property (@(posedge nvdla_core_clk) disable iff (reset)
    (wr0_en && wr1_en) |-> (wr0_addr.field.bank != wr1_addr.field.bank))
    else $error("both write ports hit bank %0d", wr0_addr.field.bank);

  // data and weight reads go to different banks
  rd_bank_conflict : assert property (@(posedge nvdla_core_clk) disable iff (reset)
    (dat_rd_en && wt_rd_en) |-> (dat_rd_addr.field.bank != wt_rd_addr.field.bank))
    else $error("both read ports hit bank %0d", dat_rd_addr.field.bank);

  // ============================================================
  // valid timing
  // ============================================================

  // every strobe comes back exactly cbuf_rd_latency cycles later
  dat_valid_after_strobe : assert property (@(posedge nvdla_core_clk) disable iff (reset)
    dat_rd_en |-> ##cbuf_rd_latency dat_rd_valid)
    else $error("dat_rd_valid missing %0d cycles after strobe", cbuf_rd_latency);

  wt_valid_after_strobe : assert property (@(posedge nvdla_core_clk) disable iff (reset)
    wt_rd_en |-> ##cbuf_rd_latency wt_rd_valid)
    else $error("wt_rd_valid missing %0d cycles after strobe", cbuf_rd_latency);

  // and a valid never shows up without a matching strobe
  dat_valid_has_strobe : assert property (@(posedge nvdla_core_clk) disable iff (reset)
    $rose(dat_rd_valid) |-> $past(dat_rd_en, cbuf_rd_latency))
    else $error("dat_rd_valid rose without a strobe");

  wt_valid_has_strobe : assert property (@(posedge nvdla_core_clk) disable iff (reset)
    $rose(wt_rd_valid) |-> $past(wt_rd_en, cbuf_rd_latency))
    else $error("wt_rd_valid rose without a strobe");

  // reset clears both valids on the next edge
  valid_low_in_reset : assert property (@(posedge nvdla_core_clk)
    reset |=> (!dat_rd_valid && !wt_rd_valid))
    else $error("read valid high during reset");

endmodule

//--- testbench/cbuf_tb.sv
// convolution buffer testbench
// table driven writes and reads against a flat-address model of the store,
// results checked in order at each valid pulse

`timescale 1ns/1ps

module cbuf_tb
  import cbuf_cfg_pkg::*;
  import cbuf_addr_pkg::*;
();

  localparam int data_width = cbuf_def_data_width;
  localparam int n_addr     = cbuf_num_banks * cbuf_bank_depth;
  localparam int max_rows   = 400;

  // row operations
  localparam int op_idle    = 0;
  localparam int op_wr0     = 1;
  localparam int op_wr1     = 2;
  localparam int op_wr_both = 3;
  localparam int op_rd_dat  = 4;
  localparam int op_rd_wt   = 5;
  localparam int op_rd_both = 6;

  typedef logic [data_width-1:0] word_t;

  logic       nvdla_core_clk;
  logic       reset;
  logic       wr0_en;
  cbuf_addr_u wr0_addr;
  word_t      wr0_data;
  logic       wr1_en;
  cbuf_addr_u wr1_addr;
  word_t      wr1_data;
  logic       dat_rd_en;
  cbuf_addr_u dat_rd_addr;
  logic       dat_rd_valid;
  word_t      dat_rd_data;
  logic       wt_rd_en;
  cbuf_addr_u wt_rd_addr;
  logic       wt_rd_valid;
  word_t      wt_rd_data;

  // stimulus table, port a is port 0 or data read, port b is port 1 or weight read
  int                        row_op     [max_rows];
  logic [cbuf_addr_bits-1:0] row_addr_a [max_rows];
  logic [cbuf_addr_bits-1:0] row_addr_b [max_rows];
  word_t                     row_data_a [max_rows];
  word_t                     row_data_b [max_rows];
  word_t                     row_exp_a  [max_rows];
  word_t                     row_exp_b  [max_rows];
  int                        num_rows = 0;

  // buffer contents by flat address
  word_t model [int];
  // expected words per client, oldest first
  word_t dat_exp_q [$];
  word_t wt_exp_q  [$];
  // strobes issued in the last cbuf_rd_latency cycles
  bit [cbuf_rd_latency-1:0] dat_hist = '0;
  bit [cbuf_rd_latency-1:0] wt_hist  = '0;

  int cycle_count   = 0;
  int timeout_limit = 0;

  cbuf_top #(
    .data_width (data_width)
  ) cbuf_top_inst (
    .nvdla_core_clk (nvdla_core_clk),
    .reset          (reset),
    .wr0_en         (wr0_en),
    .wr0_addr       (wr0_addr),
    .wr0_data       (wr0_data),
    .wr1_en         (wr1_en),
    .wr1_addr       (wr1_addr),
    .wr1_data       (wr1_data),
    .dat_rd_en      (dat_rd_en),
    .dat_rd_addr    (dat_rd_addr),
    .dat_rd_valid   (dat_rd_valid),
    .dat_rd_data    (dat_rd_data),
    .wt_rd_en       (wt_rd_en),
    .wt_rd_addr     (wt_rd_addr),
    .wt_rd_valid    (wt_rd_valid),
    .wt_rd_data     (wt_rd_data)
  );

  bind cbuf_top cbuf_chk cbuf_chk_inst (
    .nvdla_core_clk (nvdla_core_clk),
    .reset          (reset),
    .wr0_en         (wr0_en),
    .wr0_addr       (wr0_addr),
    .wr1_en         (wr1_en),
    .wr1_addr       (wr1_addr),
    .dat_rd_en      (dat_rd_en),
    .dat_rd_addr    (dat_rd_addr),
    .wt_rd_en       (wt_rd_en),
    .wt_rd_addr     (wt_rd_addr),
    .dat_rd_valid   (dat_rd_valid),
    .wt_rd_valid    (wt_rd_valid)
  );

  // 20 ns clock
  initial begin
    nvdla_core_clk = 1'b0;
    forever #10 nvdla_core_clk = ~nvdla_core_clk;
  end

  // ============================================================
  // reporting and compare
  // ============================================================

  task automatic abort_run();
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t ns: %s expected %h, got %h",
               $time, name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_valid(input string name, input bit expected, input logic actual);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t ns: %s expected %b, got %b",
               $time, name, expected, actual);
      abort_run();
    end
  endtask

  // ============================================================
  // table construction
  // ============================================================

  // data_width bits of $urandom, 32 at a time
  function automatic word_t random_word();
    word_t w;
    w = '0;
    for (int i = 0; i < data_width; i += 32) begin
      w = (w << 32) | word_t'($urandom);
    end
    return w;
  endfunction

  // writes update the model, reads take their expected word from it
  function automatic void add_row(input int op, input int a, input int b,
                                  input word_t da, input word_t db);
    row_op[num_rows]     = op;
    row_addr_a[num_rows] = cbuf_addr_bits'(a);
    row_addr_b[num_rows] = cbuf_addr_bits'(b);
    row_data_a[num_rows] = da;
    row_data_b[num_rows] = db;
    row_exp_a[num_rows]  = '0;
    row_exp_b[num_rows]  = '0;
    case (op)
      op_wr0, op_wr1: model[a] = da;
      op_wr_both: begin
        model[a] = da;
        model[b] = db;
      end
      op_rd_dat, op_rd_wt: row_exp_a[num_rows] = model[a];
      op_rd_both: begin
        row_exp_a[num_rows] = model[a];
        row_exp_b[num_rows] = model[b];
      end
      default: ;
    endcase
    num_rows++;
  endfunction

  function automatic void add_idle(input int n);
    for (int i = 0; i < n; i++) begin
      add_row(op_idle, 0, 0, '0, '0);
    end
  endfunction

  task automatic build_table();
    int a;
    int b;
    int half;
    half = cbuf_num_banks / 2;
    // fill every address through port 0, then read it all back in order
    for (int i = 0; i < n_addr; i++) begin
      add_row(op_wr0, i, 0, random_word(), '0);
    end
    add_idle(3);
    for (int i = 0; i < n_addr; i++) begin
      add_row(op_rd_dat, i, 0, '0, '0);
    end
    // back to back reads stepping across banks, four in flight
    for (int i = 0; i < n_addr; i++) begin
      a = (i % cbuf_num_banks) * cbuf_bank_depth + i / cbuf_num_banks;
      add_row(op_rd_dat, a, 0, '0, '0);
    end
    // weights on port 1 into the upper banks while port 0 fills the lower ones
    for (int i = 0; i < half * cbuf_bank_depth; i++) begin
      a = (i % half) * cbuf_bank_depth + i / half;
      b = (half + i % half) * cbuf_bank_depth + i / half;
      add_row(op_wr_both, a, b, random_word(), random_word());
    end
    add_idle(3);
    for (int i = 0; i < half * cbuf_bank_depth; i++) begin
      b = (half + i % half) * cbuf_bank_depth + i / half;
      add_row(op_rd_wt, b, 0, '0, '0);
    end
    // paired data and weight reads, always to different banks
    for (int i = 0; i < cbuf_bank_depth; i++) begin
      a = (i % cbuf_num_banks) * cbuf_bank_depth + (i * 5) % cbuf_bank_depth;
      b = ((i + half) % cbuf_num_banks) * cbuf_bank_depth + (i * 3) % cbuf_bank_depth;
      add_row(op_rd_both, a, b, '0, '0);
    end
    // overwrite then read three cycles later
    for (int k = 0; k < 8; k++) begin
      a = $urandom_range(n_addr - 1);
      add_row((k % 2 == 1) ? op_wr1 : op_wr0, a, 0, random_word(), '0);
      add_idle(2);
      add_row((k % 2 == 1) ? op_rd_wt : op_rd_dat, a, 0, '0, '0);
    end
    timeout_limit = num_rows * 4 + 40;
  endtask

  // ============================================================
  // drive and sample, both on the falling edge
  // ============================================================

  // idx below zero drives an idle cycle
  task automatic drive_row(input int idx);
    int op;
    bit dat_s;
    bit wt_s;
    op        = (idx < 0) ? op_idle : row_op[idx];
    dat_s     = 1'b0;
    wt_s      = 1'b0;
    wr0_en    = 1'b0;
    wr1_en    = 1'b0;
    dat_rd_en = 1'b0;
    wt_rd_en  = 1'b0;
    case (op)
      op_wr0: begin
        wr0_en        = 1'b1;
        wr0_addr.flat = row_addr_a[idx];
        wr0_data      = row_data_a[idx];
      end
      op_wr1: begin
        wr1_en        = 1'b1;
        wr1_addr.flat = row_addr_a[idx];
        wr1_data      = row_data_a[idx];
      end
      op_wr_both: begin
        wr0_en        = 1'b1;
        wr0_addr.flat = row_addr_a[idx];
        wr0_data      = row_data_a[idx];
        wr1_en        = 1'b1;
        wr1_addr.flat = row_addr_b[idx];
        wr1_data      = row_data_b[idx];
      end
      op_rd_dat: begin
        dat_rd_en        = 1'b1;
        dat_rd_addr.flat = row_addr_a[idx];
        dat_exp_q.push_back(row_exp_a[idx]);
        dat_s            = 1'b1;
      end
      op_rd_wt: begin
        wt_rd_en        = 1'b1;
        wt_rd_addr.flat = row_addr_a[idx];
        wt_exp_q.push_back(row_exp_a[idx]);
        wt_s            = 1'b1;
      end
      op_rd_both: begin
        dat_rd_en        = 1'b1;
        dat_rd_addr.flat = row_addr_a[idx];
        dat_exp_q.push_back(row_exp_a[idx]);
        dat_s            = 1'b1;
        wt_rd_en         = 1'b1;
        wt_rd_addr.flat  = row_addr_b[idx];
        wt_exp_q.push_back(row_exp_b[idx]);
        wt_s             = 1'b1;
      end
      default: ;
    endcase
    dat_hist = {dat_hist[cbuf_rd_latency-2:0], dat_s};
    wt_hist  = {wt_hist[cbuf_rd_latency-2:0], wt_s};
  endtask

  // valid must match the strobe issued cbuf_rd_latency cycles ago
  task automatic sample_outputs();
    word_t exp;
    check_valid("dat_rd_valid", dat_hist[cbuf_rd_latency-1], dat_rd_valid);
    check_valid("wt_rd_valid", wt_hist[cbuf_rd_latency-1], wt_rd_valid);
    if (dat_rd_valid === 1'b1) begin
      if (dat_exp_q.size() == 0) begin
        $display("data read result arrived with no request outstanding");
        abort_run();
      end else begin
        exp = dat_exp_q.pop_front();
        check_word("dat_rd_data", exp, dat_rd_data);
      end
    end
    if (wt_rd_valid === 1'b1) begin
      if (wt_exp_q.size() == 0) begin
        $display("weight read result arrived with no request outstanding");
        abort_run();
      end else begin
        exp = wt_exp_q.pop_front();
        check_word("wt_rd_data", exp, wt_rd_data);
      end
    end
  endtask

  // ============================================================
  // main sequence
  // ============================================================

  initial begin
    void'($urandom(32'hb86b0f82));
    reset       = 1'b1;
    wr0_en      = 1'b0;
    wr0_addr    = '0;
    wr0_data    = '0;
    wr1_en      = 1'b0;
    wr1_addr    = '0;
    wr1_data    = '0;
    dat_rd_en   = 1'b0;
    dat_rd_addr = '0;
    wt_rd_en    = 1'b0;
    wt_rd_addr  = '0;
    build_table();

    // three reset cycles, valids stay low
    repeat (3) begin
      @(negedge nvdla_core_clk);
      sample_outputs();
    end
    reset = 1'b0;

    // quiet after reset
    repeat (4) begin
      @(negedge nvdla_core_clk);
      sample_outputs();
      drive_row(-1);
    end

    for (int i = 0; i < num_rows; i++) begin
      @(negedge nvdla_core_clk);
      sample_outputs();
      drive_row(i);
    end

    // let the last reads come back
    while (dat_exp_q.size() != 0 || wt_exp_q.size() != 0) begin
      @(negedge nvdla_core_clk);
      sample_outputs();
      drive_row(-1);
    end
    // no stray valids afterwards
    repeat (cbuf_rd_latency + 1) begin
      @(negedge nvdla_core_clk);
      sample_outputs();
      drive_row(-1);
    end

    $display("ALL CHECKS PASSED");
    $finish;
  end

  // hang guard, limit follows the table length
  initial begin
    wait (timeout_limit > 0);
    while (cycle_count < timeout_limit) begin
      @(posedge nvdla_core_clk);
      cycle_count++;
    end
    $display("run hung, test did not end within %0d cycles", timeout_limit);
    abort_run();
  end

endmodule

//--- verilog/cbuf_addr_pkg.sv
// convolution buffer address layout
// flat address as carried on the ports, and the same bits split into bank and entry

package cbuf_addr_pkg;

  import cbuf_cfg_pkg::*;

  // bank index, selects one of the bank RAMs
  typedef logic [cbuf_bank_bits-1:0]  cbuf_bank_t;

  // entry index inside one bank
  typedef logic [cbuf_entry_bits-1:0] cbuf_entry_t;

  // bank sits in the upper bits so consecutive flat addresses
  // walk through the entries of one bank first
  typedef struct packed {
    cbuf_bank_t  bank;
    cbuf_entry_t entry;
  } cbuf_addr_field_t;

  // ============================================================
  // two views of one address word
  // ============================================================

  // flat  : what the DMA engine and sequencer drive
  // field : what the decoders look at
  typedef union packed {
    logic [cbuf_addr_bits-1:0] flat;
    cbuf_addr_field_t          field;
  } cbuf_addr_u;

endpackage

//--- verilog/cbuf_bank_array.sv
// convolution buffer bank array
// one single-port-write, single-port-read RAM per bank, with a registered
// read output that holds its value between reads

`timescale 1ns/1ps

module cbuf_bank_array
  import cbuf_cfg_pkg::*;
  import cbuf_addr_pkg::*;
#(
  parameter int data_width = cbuf_def_data_width
) (
  input  logic                                       nvdla_core_clk,
  // write side, from the write decode stage 2
  input  logic [cbuf_num_banks-1:0]                  bank_we,
  input  cbuf_entry_t [cbuf_num_banks-1:0]           bank_wa,
  input  logic [cbuf_num_banks-1:0][data_width-1:0]  bank_wd,
  // read side, from the read decode
  input  logic [cbuf_num_banks-1:0]                  bank_re,
  input  cbuf_entry_t [cbuf_num_banks-1:0]           bank_ra,
  // registered RAM output per bank
  output logic [cbuf_num_banks-1:0][data_width-1:0]  bank_rdata
);

  // ============================================================
  // bank RAMs
  // ============================================================

  for (genvar b = 0; b < cbuf_num_banks; b++) begin : g_bank

    // storage of this bank
    logic [data_width-1:0] ram [cbuf_bank_depth];

    // write port
    always_ff @(posedge nvdla_core_clk) begin
      if (bank_we[b]) begin
        ram[bank_wa[b]] <= bank_wd[b];
      end
    end

    // read port
    // same-edge read of an entry being written returns the old word,
    // both sides see the array before the nonblocking update
    always_ff @(posedge nvdla_core_clk) begin
      if (bank_re[b]) begin
        bank_rdata[b] <= ram[bank_ra[b]];
      end
    end

  end

endmodule

//--- verilog/cbuf_cfg_pkg.sv
// convolution buffer configuration
// sizes of the banked store and the fixed read latency seen at the ports

package cbuf_cfg_pkg;

  // ============================================================
  // bank layout
  // ============================================================

  // one RAM per bank, four banks
  localparam int cbuf_num_banks  = 4;
  // entries held by each bank RAM
  localparam int cbuf_bank_depth = 16;

  // address field widths, derived from the layout above
  localparam int cbuf_bank_bits  = $clog2(cbuf_num_banks);
  localparam int cbuf_entry_bits = $clog2(cbuf_bank_depth);
  // flat address is bank field on top of entry field
  localparam int cbuf_addr_bits  = cbuf_bank_bits + cbuf_entry_bits;

  // ============================================================
  // data path
  // ============================================================

  // default word width, top level may override through data_width
  localparam int cbuf_def_data_width = 64;

  // strobe to valid, in cycles:
  // read decode flop, RAM output flop, mask flop, merge flop
  localparam int cbuf_rd_latency = 4;

endpackage

//--- verilog/cbuf_rd_decode.sv
// convolution buffer read decode
// maps the data and weight read requests onto per-bank RAM reads and
// tracks which client each bank read belongs to

`timescale 1ns/1ps

module cbuf_rd_decode
  import cbuf_cfg_pkg::*;
  import cbuf_addr_pkg::*;
(
  input  logic                              nvdla_core_clk,
  input  logic                              reset,
  // feature data read request
  input  logic                              dat_rd_en,
  input  cbuf_addr_u                        dat_rd_addr,
  // weight read request
  input  logic                              wt_rd_en,
  input  cbuf_addr_u                        wt_rd_addr,
  // RAM read controls, registered at E0
  output logic [cbuf_num_banks-1:0]         bank_re,
  output cbuf_entry_t [cbuf_num_banks-1:0]  bank_ra,
  // owner flags, aligned with the RAM output after E1
  output logic [cbuf_num_banks-1:0]         dat_own,
  output logic [cbuf_num_banks-1:0]         wt_own
);

  logic [cbuf_num_banks-1:0] dat_hit;
  logic [cbuf_num_banks-1:0] wt_hit;

  // first owner stage, lines up with bank_re
  logic [cbuf_num_banks-1:0] dat_own_d1;
  logic [cbuf_num_banks-1:0] wt_own_d1;

  // ============================================================
  // bank compare
  // ============================================================

  always_comb begin
    for (int b = 0; b < cbuf_num_banks; b++) begin
      dat_hit[b] = dat_rd_en && (dat_rd_addr.field.bank == cbuf_bank_t'(b));
      wt_hit[b]  = wt_rd_en && (wt_rd_addr.field.bank == cbuf_bank_t'(b));
    end
  end

  // ============================================================
  // RAM read strobe and entry
  // ============================================================

  // one strobe per bank, whichever client asked
  always_ff @(posedge nvdla_core_clk) begin
    if (reset) begin
      bank_re <= '0;
    end else begin
      bank_re <= dat_hit | wt_hit;
    end
  end

  // data client has the entry when it hits, weight client otherwise;
  // the entry of an idle bank is never looked at
  always_ff @(posedge nvdla_core_clk) begin
    for (int b = 0; b < cbuf_num_banks; b++) begin
      bank_ra[b] <= dat_hit[b] ? dat_rd_addr.field.entry : wt_rd_addr.field.entry;
    end
  end

  // ============================================================
  // owner pipeline, E0 then E1
  // ============================================================

  always_ff @(posedge nvdla_core_clk) begin
    if (reset) begin
      dat_own_d1 <= '0;
      wt_own_d1  <= '0;
      dat_own    <= '0;
      wt_own     <= '0;
    end else begin
      dat_own_d1 <= dat_hit;
      wt_own_d1  <= wt_hit;
      // second stage covers the RAM output register
      dat_own    <= dat_own_d1;
      wt_own     <= wt_own_d1;
    end
  end

endmodule

//--- verilog/cbuf_rd_merge.sv
// convolution buffer read merge
// masks each bank word by the client that owns it, ORs the banks together
// in two register levels and raises the data and weight valid pulses

`timescale 1ns/1ps

module cbuf_rd_merge
  import cbuf_cfg_pkg::*;
#(
  parameter int data_width = cbuf_def_data_width
) (
  input  logic                                       nvdla_core_clk,
  input  logic                                       reset,
  // RAM outputs and their owners, both settled after E1
  input  logic [cbuf_num_banks-1:0][data_width-1:0]  bank_rdata,
  input  logic [cbuf_num_banks-1:0]                  dat_own,
  input  logic [cbuf_num_banks-1:0]                  wt_own,
  // results toward the sequencer
  output logic                                       dat_rd_valid,
  output logic [data_width-1:0]                      dat_rd_data,
  output logic                                       wt_rd_valid,
  output logic [data_width-1:0]                      wt_rd_data
);

  // level 1, masked word per bank and client
  logic [cbuf_num_banks-1:0][data_width-1:0] dat_word_q;
  logic [cbuf_num_banks-1:0][data_width-1:0] wt_word_q;
  // any bank carrying a result for the client
  logic                                      dat_any_q;
  logic                                      wt_any_q;

  // OR over the banks, feeds level 2
  logic [data_width-1:0] dat_or;
  logic [data_width-1:0] wt_or;

  // ============================================================
  // level 1 at E2
  // ============================================================

  // a bank read for the other client, or no read at all, becomes zero
  always_ff @(posedge nvdla_core_clk) begin
    for (int b = 0; b < cbuf_num_banks; b++) begin
      dat_word_q[b] <= bank_rdata[b] & {data_width{dat_own[b]}};
      wt_word_q[b]  <= bank_rdata[b] & {data_width{wt_own[b]}};
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (reset) begin
      dat_any_q <= 1'b0;
      wt_any_q  <= 1'b0;
    end else begin
      dat_any_q <= |dat_own;
      wt_any_q  <= |wt_own;
    end
  end

  // ============================================================
  // level 2 at E3
  // ============================================================

  // at most one bank per client is non-zero, so OR acts as a select
  always_comb begin
    dat_or = '0;
    wt_or  = '0;
    for (int b = 0; b < cbuf_num_banks; b++) begin
      dat_or = dat_or | dat_word_q[b];
      wt_or  = wt_or | wt_word_q[b];
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    dat_rd_data <= dat_or;
    wt_rd_data  <= wt_or;
  end

  // valids follow the data on the same edge
  always_ff @(posedge nvdla_core_clk) begin
    if (reset) begin
      dat_rd_valid <= 1'b0;
      wt_rd_valid  <= 1'b0;
    end else begin
      dat_rd_valid <= dat_any_q;
      wt_rd_valid  <= wt_any_q;
    end
  end

endmodule

//--- verilog/cbuf_top.sv
// convolution buffer top level
// banked store filled by two write ports (feature data, weights) and read by
// a data port and a weight port with a fixed four-cycle latency

`timescale 1ns/1ps

module cbuf_top
  import cbuf_cfg_pkg::*;
  import cbuf_addr_pkg::*;
#(
  parameter int data_width = cbuf_def_data_width
) (
  input  logic                   nvdla_core_clk,
  input  logic                   reset,
  // port 0, feature data from DMA
  input  logic                   wr0_en,
  input  cbuf_addr_u             wr0_addr,
  input  logic [data_width-1:0]  wr0_data,
  // port 1, weights from DMA
  input  logic                   wr1_en,
  input  cbuf_addr_u             wr1_addr,
  input  logic [data_width-1:0]  wr1_data,
  // feature data read
  input  logic                   dat_rd_en,
  input  cbuf_addr_u             dat_rd_addr,
  output logic                   dat_rd_valid,
  output logic [data_width-1:0]  dat_rd_data,
  // weight read
  input  logic                   wt_rd_en,
  input  cbuf_addr_u             wt_rd_addr,
  output logic                   wt_rd_valid,
  output logic [data_width-1:0]  wt_rd_data
);

  // write decode to RAMs
  logic [cbuf_num_banks-1:0]                  bank_we;
  cbuf_entry_t [cbuf_num_banks-1:0]           bank_wa;
  logic [cbuf_num_banks-1:0][data_width-1:0]  bank_wd;

  // read decode to RAMs and merge
  logic [cbuf_num_banks-1:0]                  bank_re;
  cbuf_entry_t [cbuf_num_banks-1:0]           bank_ra;
  logic [cbuf_num_banks-1:0]                  dat_own;
  logic [cbuf_num_banks-1:0]                  wt_own;

  // RAMs to merge
  logic [cbuf_num_banks-1:0][data_width-1:0]  bank_rdata;

  // ============================================================
  // write path
  // ============================================================

  cbuf_wr_decode #(
    .data_width (data_width)
  ) cbuf_wr_decode_inst (
    .nvdla_core_clk (nvdla_core_clk),
    .reset          (reset),
    .wr0_en         (wr0_en),
    .wr0_addr       (wr0_addr),
    .wr0_data       (wr0_data),
    .wr1_en         (wr1_en),
    .wr1_addr       (wr1_addr),
    .wr1_data       (wr1_data),
    .bank_we        (bank_we),
    .bank_wa        (bank_wa),
    .bank_wd        (bank_wd)
  );

  // ============================================================
  // read request path
  // ============================================================

  cbuf_rd_decode cbuf_rd_decode_inst (
    .nvdla_core_clk (nvdla_core_clk),
    .reset          (reset),
    .dat_rd_en      (dat_rd_en),
    .dat_rd_addr    (dat_rd_addr),
    .wt_rd_en       (wt_rd_en),
    .wt_rd_addr     (wt_rd_addr),
    .bank_re        (bank_re),
    .bank_ra        (bank_ra),
    .dat_own        (dat_own),
    .wt_own         (wt_own)
  );

  // storage
  cbuf_bank_array #(
    .data_width (data_width)
  ) cbuf_bank_array_inst (
    .nvdla_core_clk (nvdla_core_clk),
    .bank_we        (bank_we),
    .bank_wa        (bank_wa),
    .bank_wd        (bank_wd),
    .bank_re        (bank_re),
    .bank_ra        (bank_ra),
    .bank_rdata     (bank_rdata)
  );

  // ============================================================
  // read return path
  // ============================================================

  cbuf_rd_merge #(
    .data_width (data_width)
  ) cbuf_rd_merge_inst (
    .nvdla_core_clk (nvdla_core_clk),
    .reset          (reset),
    .bank_rdata     (bank_rdata),
    .dat_own        (dat_own),
    .wt_own         (wt_own),
    .dat_rd_valid   (dat_rd_valid),
    .dat_rd_data    (dat_rd_data),
    .wt_rd_valid    (wt_rd_valid),
    .wt_rd_data     (wt_rd_data)
  );

endmodule

//--- verilog/cbuf_wr_decode.sv
// convolution buffer write decode
// turns the feature and weight write ports into per-bank write controls,
// two register stages deep so the RAM write lands on the third edge

`timescale 1ns/1ps

module cbuf_wr_decode
  import cbuf_cfg_pkg::*;
  import cbuf_addr_pkg::*;
#(
  parameter int data_width = cbuf_def_data_width
) (
  input  logic                                       nvdla_core_clk,
  input  logic                                       reset,
  // port 0 feature data, port 1 weights
  input  logic                                       wr0_en,
  input  cbuf_addr_u                                 wr0_addr,
  input  logic [data_width-1:0]                      wr0_data,
  input  logic                                       wr1_en,
  input  cbuf_addr_u                                 wr1_addr,
  input  logic [data_width-1:0]                      wr1_data,
  // per-bank write controls toward the RAMs
  output logic [cbuf_num_banks-1:0]                  bank_we,
  output cbuf_entry_t [cbuf_num_banks-1:0]           bank_wa,
  output logic [cbuf_num_banks-1:0][data_width-1:0]  bank_wd
);

  // one-hot bank hit per port, before the first flop
  logic [cbuf_num_banks-1:0] wr0_hit;
  logic [cbuf_num_banks-1:0] wr1_hit;

  // stage 1, per port
  logic [cbuf_num_banks-1:0] wr0_hit_q;
  logic [cbuf_num_banks-1:0] wr1_hit_q;
  cbuf_entry_t               wr0_entry_q;
  cbuf_entry_t               wr1_entry_q;
  logic [data_width-1:0]     wr0_data_q;
  logic [data_width-1:0]     wr1_data_q;

  // ============================================================
  // bank compare
  // ============================================================

  always_comb begin
    for (int b = 0; b < cbuf_num_banks; b++) begin
      wr0_hit[b] = wr0_en && (wr0_addr.field.bank == cbuf_bank_t'(b));
      wr1_hit[b] = wr1_en && (wr1_addr.field.bank == cbuf_bank_t'(b));
    end
  end

  // ============================================================
  // stage 1 at E0, per port
  // ============================================================

  always_ff @(posedge nvdla_core_clk) begin
    if (reset) begin
      wr0_hit_q <= '0;
      wr1_hit_q <= '0;
    end else begin
      wr0_hit_q <= wr0_hit;
      wr1_hit_q <= wr1_hit;
    end
  end

  // address and data ride along without reset
  always_ff @(posedge nvdla_core_clk) begin
    wr0_entry_q <= wr0_addr.field.entry;
    wr1_entry_q <= wr1_addr.field.entry;
    wr0_data_q  <= wr0_data;
    wr1_data_q  <= wr1_data;
  end

  // ============================================================
  // stage 2 at E1, per bank
  // ============================================================

  // the two ports never share a bank in one cycle, so the port 0 hit
  // alone picks the source; a bank with no hit keeps its old payload
  always_ff @(posedge nvdla_core_clk) begin
    if (reset) begin
      bank_we <= '0;
    end else begin
      bank_we <= wr0_hit_q | wr1_hit_q;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    for (int b = 0; b < cbuf_num_banks; b++) begin
      if (wr0_hit_q[b]) begin
        bank_wa[b] <= wr0_entry_q;
        bank_wd[b] <= wr0_data_q;
      end else if (wr1_hit_q[b]) begin
        bank_wa[b] <= wr1_entry_q;
        bank_wd[b] <= wr1_data_q;
      end
    end
  end

endmodule
